// ==== Bender.yml ====
package:
  name: bc_node

sources:
  # Package first, then leaf modules, then the top level
  - rtl/bc_pkg.sv
  - rtl/bc_dmem.sv
  - rtl/bc_capture_fifo.sv
  - rtl/bc_tx_fsm.sv
  - rtl/bc_msg_counter.sv
  - rtl/bc_node.sv
  - target: test
    files:
      - tests/bc_node_tb.sv

// ==== bc_node.f ====
rtl/bc_pkg.sv
rtl/bc_dmem.sv
rtl/bc_capture_fifo.sv
rtl/bc_tx_fsm.sv
rtl/bc_msg_counter.sv
rtl/bc_node.sv
tests/bc_node_tb.sv

// ==== rtl/bc_capture_fifo.sv ====
`timescale 1ns/1ps

module bc_capture_fifo import bc_pkg::*; #(
  parameter int DEPTH = 4
) (
  input  logic       clk,
  input  logic       rst,

  // Taken core write
  input  logic       wr_take,
  input  dmem_addr_t wr_addr,
  input  strb_t      wr_strb,
  input  word_t      wr_data,

  // Consumer side
  input  logic       pop,
  output bc_msg_t    head,
  output logic       not_empty,
  output logic       full,
  output logic       push
);

  bc_msg_t                      msg_mem [DEPTH];
  logic [$clog2(DEPTH)-1:0]     wr_ptr_q;
  logic [$clog2(DEPTH)-1:0]     rd_ptr_q;
  logic [$clog2(DEPTH+1)-1:0]   count_q;
  logic                         in_region;
  dmem_addr_t                   region_addr;
  msg_addr_t                    msg_offset;
  bc_msg_t                      msg;

  //////////////////////////////////////////////////
  // Region decode and packing
  //////////////////////////////////////////////////
  assign in_region   = wr_addr >= dmem_addr_t'(BC_START_ADDR);
  assign region_addr = wr_addr - dmem_addr_t'(BC_START_ADDR);
  assign msg_offset  = region_addr[MSG_ADDR_WIDTH+1:2];
  assign msg         = {wr_data, wr_strb, msg_offset};

  assign push = wr_take && in_region;

  //////////////////////////////////////////////////
  // Circular buffer
  //////////////////////////////////////////////////
  assign head      = msg_mem[rd_ptr_q];
  assign not_empty = count_q != '0;
  assign full      = count_q == DEPTH;

  always_ff @(posedge clk) begin
    if (push) begin
      msg_mem[wr_ptr_q] <= msg;
    end
  end

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == DEPTH - 1) ? '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == DEPTH - 1) ? '0 : rd_ptr_q + 1'b1;
      end
    end
  end

  // Occupancy
  always_ff @(posedge clk) begin
    if (rst) begin
      count_q <= '0;
    end else begin
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

// ==== rtl/bc_dmem.sv ====
`timescale 1ns/1ps

module bc_dmem import bc_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  // Core port, already qualified by ready
  input  logic       core_en,
  input  logic       core_wen,
  input  strb_t      core_strb,
  input  dmem_addr_t core_addr,
  input  word_t      core_wr_data,

  // Incoming broadcast writes
  input  logic       bc_wen,
  input  msg_addr_t  bc_offset,
  input  strb_t      bc_strb,
  input  word_t      bc_wr_data,

  // Registered read
  output word_t      rd_data,
  output logic       rd_valid
);

  word_t                      mem [DMEM_SIZE/4];
  logic [DMEM_ADDR_WIDTH-3:0] core_word;
  logic [DMEM_ADDR_WIDTH-3:0] bc_word;
  dmem_addr_t                 bc_addr;
  logic                       core_wr;
  logic                       core_rd;

  // Word aligned, low two bits dropped
  assign core_word = core_addr[DMEM_ADDR_WIDTH-1:2];
  assign core_wr   = core_en && core_wen;
  assign core_rd   = core_en && !core_wen;

  // Offset counts words from the region base
  assign bc_addr = dmem_addr_t'(BC_START_ADDR) + dmem_addr_t'({bc_offset, 2'b00});
  assign bc_word = bc_addr[DMEM_ADDR_WIDTH-1:2];

  //////////////////////////////////////////////////
  // Byte-strobed writes
  //////////////////////////////////////////////////
  // Broadcast byte is assigned last so it wins on overlap
  always_ff @(posedge clk) begin
    for (int b = 0; b < 4; b++) begin
      if (core_wr && core_strb[b]) begin
        mem[core_word][8*b +: 8] <= core_wr_data[8*b +: 8];
      end
      if (bc_wen && bc_strb[b]) begin
        mem[bc_word][8*b +: 8] <= bc_wr_data[8*b +: 8];
      end
    end
  end

  //////////////////////////////////////////////////
  // One-cycle read
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (core_rd) begin
      rd_data <= mem[core_word];
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      rd_valid <= 1'b0;
    end else begin
      rd_valid <= core_rd;
    end
  end

endmodule

// ==== rtl/bc_msg_counter.sv ====
`timescale 1ns/1ps

module bc_msg_counter import bc_pkg::*; (
  input  logic   clk,
  input  logic   rst,

  // Event strobes
  input  logic   pushed,
  input  logic   sent,
  input  logic   received,

  output count_t sent_count,
  output count_t recv_count,
  output count_t pending_count
);

  //////////////////////////////////////////////////
  // Saturating event counters
  //////////////////////////////////////////////////
  always_ff @(posedge clk) begin
    if (rst) begin
      sent_count <= '0;
      recv_count <= '0;
    end else begin
      if (sent && sent_count != '1) begin
        sent_count <= sent_count + 1'b1;
      end
      if (received && recv_count != '1) begin
        recv_count <= recv_count + 1'b1;
      end
    end
  end

  // Messages in the FIFO plus the one held for transmit
  always_ff @(posedge clk) begin
    if (rst) begin
      pending_count <= '0;
    end else begin
      case ({pushed, sent})
        2'b10:   pending_count <= pending_count + 1'b1;
        2'b01:   pending_count <= pending_count - 1'b1;
        default: pending_count <= pending_count;
      endcase
    end
  end

endmodule

// ==== rtl/bc_node.sv ====
`timescale 1ns/1ps

module bc_node import bc_pkg::*; (
  input  logic       clk,
  input  logic       rst,

  // Core data memory port
  input  logic       core_mem_en,
  input  logic       core_mem_wen,
  input  strb_t      core_mem_strb,
  input  dmem_addr_t core_mem_addr,
  input  word_t      core_mem_wr_data,
  output logic       core_mem_ready,
  output word_t      core_mem_rd_data,
  output logic       core_mem_rd_valid,

  // Broadcast messages
  input  bc_msg_t    bc_msg_in,
  input  logic       bc_msg_in_valid,
  output bc_msg_t    bc_msg_out,
  output logic       bc_msg_out_valid,
  input  logic       bc_msg_out_ready,

  // Message statistics
  output count_t     msg_sent_count,
  output count_t     msg_recv_count,
  output count_t     msg_pending_count
);

  logic    core_take;
  logic    wr_take;
  logic    fifo_full;
  logic    fifo_not_empty;
  logic    fifo_pop;
  logic    fifo_push;
  bc_msg_t fifo_head;
  logic    msg_sent;

  // Core is held off for every access while the queue is full
  assign core_mem_ready = !fifo_full;
  assign core_take      = core_mem_en && !fifo_full;
  assign wr_take        = core_take && core_mem_wen;

  //////////////////////////////////////////////////
  // Data memory
  //////////////////////////////////////////////////
  bc_dmem bc_dmem_i (
    .clk          (clk),
    .rst          (rst),
    .core_en      (core_take),
    .core_wen     (core_mem_wen),
    .core_strb    (core_mem_strb),
    .core_addr    (core_mem_addr),
    .core_wr_data (core_mem_wr_data),
    .bc_wen       (bc_msg_in_valid),
    .bc_offset    (bc_msg_in[MSG_ADDR_WIDTH-1:0]),
    .bc_strb      (bc_msg_in[MSG_ADDR_WIDTH +: 4]),
    .bc_wr_data   (bc_msg_in[MSG_WIDTH-1 -: 32]),
    .rd_data      (core_mem_rd_data),
    .rd_valid     (core_mem_rd_valid)
  );

  //////////////////////////////////////////////////
  // Outgoing path
  //////////////////////////////////////////////////
  bc_capture_fifo #(
    .DEPTH (4)
  ) bc_capture_fifo_i (
    .clk       (clk),
    .rst       (rst),
    .wr_take   (wr_take),
    .wr_addr   (core_mem_addr),
    .wr_strb   (core_mem_strb),
    .wr_data   (core_mem_wr_data),
    .pop       (fifo_pop),
    .head      (fifo_head),
    .not_empty (fifo_not_empty),
    .full      (fifo_full),
    .push      (fifo_push)
  );

  bc_tx_fsm bc_tx_fsm_i (
    .clk            (clk),
    .rst            (rst),
    .fifo_head      (fifo_head),
    .fifo_not_empty (fifo_not_empty),
    .fifo_pop       (fifo_pop),
    .msg_out        (bc_msg_out),
    .msg_out_valid  (bc_msg_out_valid),
    .msg_out_ready  (bc_msg_out_ready),
    .sent           (msg_sent)
  );

  // Statistics
  bc_msg_counter bc_msg_counter_i (
    .clk           (clk),
    .rst           (rst),
    .pushed        (fifo_push),
    .sent          (msg_sent),
    .received      (bc_msg_in_valid),
    .sent_count    (msg_sent_count),
    .recv_count    (msg_recv_count),
    .pending_count (msg_pending_count)
  );

endmodule

// ==== rtl/bc_pkg.sv ====
package bc_pkg;

  //////////////////////////////////////////////////
  // Data memory geometry
  //////////////////////////////////////////////////
  localparam int DMEM_SIZE       = 4096;
  localparam int DMEM_ADDR_WIDTH = 12;

  //////////////////////////////////////////////////
  // Broadcast region, top of data memory
  //////////////////////////////////////////////////
  localparam int BC_REGION_SIZE  = 256;
  localparam int BC_START_ADDR   = DMEM_SIZE - BC_REGION_SIZE;

  // Word offset inside the region
  localparam int MSG_ADDR_WIDTH  = 6;

  // Data, strobes, then offset
  localparam int MSG_WIDTH       = 42;

  // Vector types
  typedef logic [DMEM_ADDR_WIDTH-1:0] dmem_addr_t;
  typedef logic [31:0]                word_t;
  typedef logic [3:0]                 strb_t;
  typedef logic [MSG_ADDR_WIDTH-1:0]  msg_addr_t;
  typedef logic [MSG_WIDTH-1:0]       bc_msg_t;
  typedef logic [15:0]                count_t;

  // Transmit FSM states
  typedef enum logic {
    TX_IDLE,
    TX_SEND
  } bc_tx_state_t;

endpackage

// ==== rtl/bc_tx_fsm.sv ====
`timescale 1ns/1ps

module bc_tx_fsm import bc_pkg::*; (
  input  logic    clk,
  input  logic    rst,

  // Capture FIFO side
  input  bc_msg_t fifo_head,
  input  logic    fifo_not_empty,
  output logic    fifo_pop,

  // Outgoing message port
  output bc_msg_t msg_out,
  output logic    msg_out_valid,
  input  logic    msg_out_ready,

  // One pulse per completed handshake
  output logic    sent
);

  bc_tx_state_t state_q;
  bc_tx_state_t state_d;

  //////////////////////////////////////////////////
  // Next state and pop decision
  //////////////////////////////////////////////////
  always_comb begin
    state_d  = state_q;
    fifo_pop = 1'b0;
    sent     = 1'b0;
    case (state_q)
      TX_IDLE: begin
        if (fifo_not_empty) begin
          fifo_pop = 1'b1;
          state_d  = TX_SEND;
        end
      end
      TX_SEND: begin
        if (msg_out_ready) begin
          sent = 1'b1;
          // Back to back when another message waits
          if (fifo_not_empty) begin
            fifo_pop = 1'b1;
          end else begin
            state_d = TX_IDLE;
          end
        end
      end
      default: begin
        state_d = TX_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= TX_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Output register, held while ready is low
  always_ff @(posedge clk) begin
    if (fifo_pop) begin
      msg_out <= fifo_head;
    end
  end

  assign msg_out_valid = state_q == TX_SEND;

endmodule

// ==== tests/bc_node_tb.sv ====
`timescale 1ns/1ps

module bc_node_tb import bc_pkg::*; ();

  localparam int FIFO_DEPTH     = 4;
  localparam int NUM_OPS        = 400;
  localparam int ACCESS_TIMEOUT = 100;
  localparam int DRAIN_TIMEOUT  = 200;

  logic       clk = 1'b0;
  logic       rst;
  logic       core_mem_en;
  logic       core_mem_wen;
  strb_t      core_mem_strb;
  dmem_addr_t core_mem_addr;
  word_t      core_mem_wr_data;
  logic       core_mem_ready;
  word_t      core_mem_rd_data;
  logic       core_mem_rd_valid;
  bc_msg_t    bc_msg_in;
  logic       bc_msg_in_valid;
  bc_msg_t    bc_msg_out;
  logic       bc_msg_out_valid;
  logic       bc_msg_out_ready;
  count_t     msg_sent_count;
  count_t     msg_recv_count;
  count_t     msg_pending_count;

  // Model state
  integer     seed = 85;
  logic [7:0] model_mem [DMEM_SIZE];
  bc_msg_t    exp_msgs [$];
  int         model_sent;
  int         model_recv;
  int         model_pushed;
  logic       hold_low;
  logic       collide;
  msg_addr_t  collide_off;

  always #2 clk = ~clk;

  bc_node bc_node_i (.*);

  //////////////////////////////////////////////////
  // Failure reporting
  //////////////////////////////////////////////////
  task automatic fail_run();
    $display("Regression failed");
    $fatal(1);
  endtask

  task automatic fail_because(input string what);
    $display("%s at time %0t", what, $time);
    fail_run();
  endtask

  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    assert (actual === expected) else begin
      $display("ERROR t=%0t %s expected=%h actual=%h", $time, name, expected, actual);
      fail_run();
    end
  endtask

  //////////////////////////////////////////////////
  // Memory model
  //////////////////////////////////////////////////
  // Byte lane b of the word holds bits 8b+7..8b
  function automatic word_t model_word(input dmem_addr_t addr);
    int base;
    base = {addr[DMEM_ADDR_WIDTH-1:2], 2'b00};
    return {model_mem[base+3], model_mem[base+2], model_mem[base+1], model_mem[base]};
  endfunction

  task automatic apply_write(input dmem_addr_t addr, input strb_t strb, input word_t data);
    int base;
    base = {addr[DMEM_ADDR_WIDTH-1:2], 2'b00};
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        model_mem[base+b] = data[8*b +: 8];
      end
    end
  endtask

  // Low 256 bytes or the broadcast region
  function automatic dmem_addr_t pick_addr(input logic region);
    if (region) begin
      return dmem_addr_t'(BC_START_ADDR + ($random(seed) & 255));
    end
    return dmem_addr_t'($random(seed) & 255);
  endfunction

  //////////////////////////////////////////////////
  // One clock cycle, entered and left 1 ns after the edge
  //////////////////////////////////////////////////
  task automatic step(input logic en, input logic wen, input strb_t strb,
                      input dmem_addr_t addr, input word_t data, output logic taken);
    logic      rd_exp_valid;
    word_t     rd_exp;
    logic      held;
    bc_msg_t   held_msg;
    msg_addr_t in_off;
    strb_t     in_strb;
    word_t     in_data;
    core_mem_en      = en;
    core_mem_wen     = wen;
    core_mem_strb    = strb;
    core_mem_addr    = addr;
    core_mem_wr_data = data;
    bc_msg_in_valid  = ($random(seed) & 3) == 0;
    in_off           = msg_addr_t'($random(seed));
    in_strb          = strb_t'($random(seed));
    in_data          = word_t'($random(seed));
    // Directed hit on the word the core writes
    if (collide) begin
      bc_msg_in_valid = 1'b1;
      in_off          = collide_off;
      in_strb         = 4'b0110;
    end
    bc_msg_in        = {in_data, in_strb, in_off};
    bc_msg_out_ready = hold_low ? 1'b0 : (($random(seed) & 3) != 0);

    // Outgoing message must be the oldest one expected
    if (bc_msg_out_valid) begin
      assert (exp_msgs.size() != 0) else fail_because("Outgoing message with no write behind it");
      check_value("bc_msg_out", exp_msgs[0], bc_msg_out);
      if (bc_msg_out_ready) begin
        void'(exp_msgs.pop_front());
        model_sent++;
      end
    end
    held     = bc_msg_out_valid && !bc_msg_out_ready;
    held_msg = bc_msg_out;

    taken        = en && core_mem_ready;
    rd_exp_valid = taken && !wen;
    rd_exp       = model_word(addr);
    if (taken && wen) begin
      apply_write(addr, strb, data);
      if (addr >= BC_START_ADDR) begin
        exp_msgs.push_back({data, strb, msg_addr_t'((addr - BC_START_ADDR) >> 2)});
        model_pushed++;
      end
    end
    // Incoming bytes land after the core bytes
    if (bc_msg_in_valid) begin
      apply_write(dmem_addr_t'(BC_START_ADDR + 4 * int'(in_off)), in_strb, in_data);
      model_recv++;
    end

    @(posedge clk);
    #1;
    check_value("core_mem_rd_valid", rd_exp_valid, core_mem_rd_valid);
    if (rd_exp_valid) begin
      check_value("core_mem_rd_data", rd_exp, core_mem_rd_data);
    end
    if (held) begin
      check_value("bc_msg_out_valid", 1'b1, bc_msg_out_valid);
      check_value("bc_msg_out", held_msg, bc_msg_out);
    end
    check_value("msg_sent_count", count_t'(model_sent), msg_sent_count);
    check_value("msg_recv_count", count_t'(model_recv), msg_recv_count);
    check_value("msg_pending_count", count_t'(model_pushed - model_sent), msg_pending_count);
  endtask

  // Core holds the access until it is taken
  task automatic core_access(input logic wen, input strb_t strb, input dmem_addr_t addr,
                             input word_t data);
    logic taken;
    int   waited;
    taken  = 1'b0;
    waited = 0;
    while (!taken && waited < ACCESS_TIMEOUT) begin
      step(1'b1, wen, strb, addr, data, taken);
      waited++;
    end
    if (!taken) begin
      fail_because("Core access was never accepted");
    end
  endtask

  task automatic idle_cycle();
    logic taken;
    step(1'b0, 1'b0, '0, '0, '0, taken);
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    while ((exp_msgs.size() != 0 || bc_msg_out_valid) && waited < DRAIN_TIMEOUT) begin
      idle_cycle();
      waited++;
    end
    if (exp_msgs.size() != 0 || bc_msg_out_valid) begin
      fail_because("Outgoing messages did not drain");
    end
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////
  initial begin
    logic       taken;
    logic       is_write;
    dmem_addr_t addr;
    word_t      data;
    int         writes;
    rst = 1'b1;
    core_mem_en = 1'b0;
    core_mem_wen = 1'b0;
    core_mem_strb = '0;
    core_mem_addr = '0;
    core_mem_wr_data = '0;
    bc_msg_in = '0;
    bc_msg_in_valid = 1'b0;
    bc_msg_out_ready = 1'b0;
    hold_low = 1'b0;
    collide = 1'b0;
    collide_off = '0;
    model_sent = 0;
    model_recv = 0;
    model_pushed = 0;
    repeat (5) @(posedge clk);
    #1;
    rst = 1'b0;

    check_value("bc_msg_out_valid", 1'b0, bc_msg_out_valid);
    check_value("core_mem_rd_valid", 1'b0, core_mem_rd_valid);
    check_value("core_mem_ready", 1'b1, core_mem_ready);
    check_value("msg_sent_count", '0, msg_sent_count);
    check_value("msg_recv_count", '0, msg_recv_count);
    check_value("msg_pending_count", '0, msg_pending_count);

    // Fill both address windows so every read has a known answer
    for (int w = 0; w < 128; w++) begin
      addr = (w < 64) ? dmem_addr_t'(4 * w) : dmem_addr_t'(BC_START_ADDR + 4 * (w - 64));
      core_access(1'b1, '1, addr, {4'ha, addr, 4'h5, ~addr});
    end

    // Random reads and writes, half the writes in the region
    for (int i = 0; i < NUM_OPS; i++) begin
      is_write = $random(seed) & 1;
      addr     = pick_addr($random(seed) & 1);
      if (is_write) begin
        core_access(1'b1, strb_t'($random(seed)), addr, word_t'($random(seed)));
      end else begin
        core_access(1'b0, '0, addr, '0);
      end
      if (($random(seed) & 3) == 0) begin
        idle_cycle();
      end
    end

    // Core and incoming write to one region word in the same cycle
    addr        = pick_addr(1'b1);
    collide_off = msg_addr_t'((addr - BC_START_ADDR) >> 2);
    collide     = 1'b1;
    core_access(1'b1, '1, addr, word_t'($random(seed)));
    collide     = 1'b0;
    core_access(1'b0, '0, addr, '0);

    // Back-pressure until the queue fills
    drain();
    hold_low = 1'b1;
    writes   = 0;
    while (core_mem_ready && writes < FIFO_DEPTH + 2) begin
      core_access(1'b1, '1, pick_addr(1'b1), word_t'($random(seed)));
      writes++;
    end
    // Queue entries plus the message held for transmit
    assert (!core_mem_ready && writes == FIFO_DEPTH + 1) else begin
      fail_because("Core was not held off exactly when the queue filled");
    end
    addr = pick_addr(1'b1);
    data = word_t'($random(seed));
    repeat (6) begin
      step(1'b1, 1'b1, '1, addr, data, taken);
      assert (!taken) else fail_because("Write taken while the queue was full");
    end
    hold_low = 1'b0;
    core_access(1'b1, '1, addr, data);
    core_access(1'b0, '0, addr, '0);
    drain();

    $display("Regression passed");
    $finish;
  end

endmodule
